/* Bender.yml */
package:
  name: vaddr_gen

sources:
  - rtl/axi_addr_pkg.sv
  - rtl/vinsn_pkg.sv
  - rtl/vmem_decoder.sv
  - rtl/burst_planner.sv
  - rtl/ax_issue_queue.sv
  - rtl/vaddr_gen.sv
  - target: test
    files:
      - bench/vaddr_gen_tb.sv

/* bench/vaddr_gen_tb.sv */
/*
 * Testbench for the vector load/store address generator
 * Table-driven instructions, random AXI and LSU ready, in-order request checks
 */
`default_nettype none

module vaddr_gen_tb;

  typedef struct packed {
    vinsn_pkg::vec_req_t insn;
    logic [7:0]          pend;
    logic [7:0]          stall;
    logic                exp_err;
    logic [15:0]         n_req;
  } entry_t;

  logic                   clk_i;
  logic                   rst_ni;
  vinsn_pkg::vec_req_t    vinsn_i;
  logic                   vinsn_valid_i;
  logic                   core_st_pending_i;
  logic                   ack_o;
  logic                   error_o;
  axi_addr_pkg::axi_ax_t  ar_o;
  logic                   ar_valid_o;
  logic                   ar_ready_i;
  axi_addr_pkg::axi_ax_t  aw_o;
  logic                   aw_valid_o;
  logic                   aw_ready_i;
  axi_addr_pkg::lsu_cmd_t lsu_cmd_o;
  logic                   lsu_cmd_valid_o;
  logic                   ldu_ready_i;
  logic                   stu_ready_i;

  entry_t                 stim [$];
  axi_addr_pkg::lsu_cmd_t exp_q [$];
  integer                 seed;
  int                     err_count;
  int                     ax_idx;
  int                     pop_idx;
  int                     wd_cycles;
  logic                   hold_lsu;

  vaddr_gen dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  task automatic plan_requests(input vinsn_pkg::vec_req_t v, output int n);
    logic [31:0] a, l, bytes, last, page_end, used;
    logic        is_load;
    axi_addr_pkg::lsu_cmd_t c;
    n       = 0;
    is_load = (v.op == vinsn_pkg::VLE) || (v.op == vinsn_pkg::VLSE);
    a       = v.addr;
    l       = {16'b0, v.vl};
    if (v.op > vinsn_pkg::VSSE || (v.addr & ((32'd1 << v.vew) - 1)) != 0) begin
      l = 0;
    end
    while (l > 0) begin
      c.addr    = a;
      c.is_load = is_load;
      if (v.op == vinsn_pkg::VLE || v.op == vinsn_pkg::VSE) begin
        bytes = l << v.vew;
        if (bytes > 256 * 8) begin
          bytes = 256 * 8;
        end
        last     = ((a + bytes - 1) / 8) * 8 + 7;
        page_end = (a / 4096) * 4096 + 4095;
        if (last > page_end) begin
          last = page_end;
        end
        c.len  = 8'((last - (a / 8) * 8 + 1) / 8 - 1);
        c.size = 3'd3;
        used   = (last - a + 1) >> v.vew;
        l      = (used >= l) ? 0 : l - used;
        a      = last + 1;
      end else begin
        c.len  = 8'd0;
        c.size = 3'(v.vew);
        a      = a + v.stride;
        l      = l - 1;
      end
      exp_q.push_back(c);
      n++;
    end
  endtask

  task automatic add_entry(input vinsn_pkg::vop_e op, input logic [31:0] addr,
                           input logic [15:0] vl, input logic [31:0] stride,
                           input vinsn_pkg::vew_e vew, input int pend, input int stall,
                           input logic exp_err);
    entry_t e;
    int     n;
    e.insn.op     = op;
    e.insn.addr   = addr;
    e.insn.vl     = vl;
    e.insn.stride = stride;
    e.insn.vew    = vew;
    e.pend        = 8'(pend);
    e.stall       = 8'(stall);
    e.exp_err     = exp_err;
    plan_requests(e.insn, n);
    e.n_req = 16'(n);
    stim.push_back(e);
  endtask

  //////////////////////////////////////////////////
  // Monitor
  //////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp, act);
    err_count++;
  endtask

  task automatic check_request(input axi_addr_pkg::axi_ax_t ax, input logic is_load,
                               input string chan);
    axi_addr_pkg::lsu_cmd_t e;
    if (ax_idx >= exp_q.size()) begin
      $display("ERROR at %0t: unexpected %s request at address %h", $time, chan, ax.addr);
      err_count++;
    end else begin
      e = exp_q[ax_idx];
      if (ax.addr != e.addr) report_mismatch({chan, ".addr"}, e.addr, ax.addr);
      if (ax.len != e.len) report_mismatch({chan, ".len"}, e.len, ax.len);
      if (ax.size != e.size) report_mismatch({chan, ".size"}, e.size, ax.size);
      if (ax.burst != axi_addr_pkg::BURST_INCR) begin
        report_mismatch({chan, ".burst"}, axi_addr_pkg::BURST_INCR, ax.burst);
      end
      if (ax.cache != axi_addr_pkg::CACHE_MODIFIABLE) begin
        report_mismatch({chan, ".cache"}, axi_addr_pkg::CACHE_MODIFIABLE, ax.cache);
      end
      if (is_load != e.is_load) report_mismatch("request is_load", e.is_load, is_load);
    end
    ax_idx++;
  endtask

  task automatic check_pop();
    axi_addr_pkg::lsu_cmd_t e;
    if (pop_idx >= exp_q.size()) begin
      $display("ERROR at %0t: lsu_cmd_o popped with no request issued", $time);
      err_count++;
    end else begin
      e = exp_q[pop_idx];
      if (lsu_cmd_o.addr != e.addr) begin
        report_mismatch("lsu_cmd_o.addr", e.addr, lsu_cmd_o.addr);
      end
      if (lsu_cmd_o.len != e.len) begin
        report_mismatch("lsu_cmd_o.len", e.len, lsu_cmd_o.len);
      end
      if (lsu_cmd_o.size != e.size) begin
        report_mismatch("lsu_cmd_o.size", e.size, lsu_cmd_o.size);
      end
      if (lsu_cmd_o.is_load != e.is_load) begin
        report_mismatch("lsu_cmd_o.is_load", e.is_load, lsu_cmd_o.is_load);
      end
    end
    pop_idx++;
  endtask

  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (ar_valid_o && ar_ready_i) check_request(ar_o, 1'b1, "ar_o");
      if (aw_valid_o && aw_ready_i) check_request(aw_o, 1'b0, "aw_o");
      if (lsu_cmd_valid_o && (ldu_ready_i || stu_ready_i)) check_pop();
      if (core_st_pending_i && aw_valid_o) begin
        $display("ERROR at %0t: aw_valid_o raised while scalar stores pending", $time);
        err_count++;
      end
      // The command queue holds two entries
      if (ax_idx - pop_idx > 2) begin
        $display("ERROR at %0t: %0d requests outstanding toward the LSUs", $time,
                 ax_idx - pop_idx);
        err_count++;
      end
    end
  end

  // Random ready on AXI and LSU sides
  always @(posedge clk_i) begin
    ar_ready_i <= ($random(seed) & 3) != 0;
    aw_ready_i <= ($random(seed) & 3) != 0;
    ldu_ready_i <= hold_lsu ? 1'b0 : (($random(seed) & 1) != 0);
    stu_ready_i <= hold_lsu ? 1'b0 : (($random(seed) & 1) != 0);
  end

  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk_i);
    $display("Watchdog timeout after %0d cycles", wd_cycles);
    $display("Finished with errors");
    $finish;
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic run_entry(input int idx, inout int exp_done);
    entry_t e;
    int     cycles;
    int     errs_before;
    int     limit;
    logic   ignored;
    logic   got_ack;
    e           = stim[idx];
    errs_before = err_count;
    exp_done    = exp_done + e.n_req;
    ignored     = e.insn.op > vinsn_pkg::VSSE;
    limit       = ignored ? 20 : 300 + e.stall + e.pend;
    cycles      = 0;
    got_ack     = 1'b0;
    vinsn_i           <= e.insn;
    vinsn_valid_i     <= 1'b1;
    core_st_pending_i <= (e.pend != 0);
    hold_lsu          <= (e.stall != 0);
    while (!got_ack && cycles < limit) begin
      @(posedge clk_i);
      cycles++;
      if (error_o && !ack_o) begin
        $display("ERROR at %0t: error_o raised without ack_o", $time);
        err_count++;
      end
      if (ack_o) begin
        got_ack = 1'b1;
        if (error_o != e.exp_err) report_mismatch("error_o", e.exp_err, error_o);
      end
      if (cycles == e.pend) core_st_pending_i <= 1'b0;
      if (cycles == e.stall) hold_lsu <= 1'b0;
    end
    vinsn_valid_i     <= 1'b0;
    core_st_pending_i <= 1'b0;
    hold_lsu          <= 1'b0;
    if (ignored && got_ack) begin
      $display("ERROR at %0t: ack_o given for a non-memory instruction", $time);
      err_count++;
    end
    if (!ignored && !got_ack) begin
      $display("ERROR at %0t: no ack_o within %0d cycles", $time, limit);
      err_count++;
    end
    if (ax_idx != exp_done) begin
      $display("ERROR at %0t: %0d requests issued so far, expected %0d", $time, ax_idx,
               exp_done);
      err_count++;
    end
    $display("Entry %0d op %0d: %s", idx, e.insn.op,
             (err_count == errs_before) ? "ok" : "failed");
    @(posedge clk_i);
  endtask

  initial begin
    int exp_done;
    int cycles;
    rst_ni            = 1'b0;
    vinsn_i           = '0;
    vinsn_valid_i     = 1'b0;
    core_st_pending_i = 1'b0;
    ar_ready_i        = 1'b0;
    aw_ready_i        = 1'b0;
    ldu_ready_i       = 1'b0;
    stu_ready_i       = 1'b0;
    hold_lsu          = 1'b0;
    seed              = 13420;
    err_count         = 0;
    ax_idx            = 0;
    pop_idx           = 0;
    exp_done          = 0;
    wd_cycles         = 0;
    // Page split and 256-beat cap, LSUs stalled at first
    add_entry(vinsn_pkg::VLE, 32'h0000_0E00, 16'd600, 32'd0, vinsn_pkg::EW64, 0, 40, 1'b0);
    add_entry(vinsn_pkg::VSSE, 32'h0000_2000, 16'd5, 32'd24, vinsn_pkg::EW32, 0, 0, 1'b0);
    add_entry(vinsn_pkg::VLSE, 32'h0000_3010, 16'd4, 32'hFFFF_FFFA, vinsn_pkg::EW16,
              0, 0, 1'b0);
    add_entry(vinsn_pkg::VLE, 32'h0000_1004, 16'd8, 32'd0, vinsn_pkg::EW64, 0, 0, 1'b1);
    add_entry(vinsn_pkg::VSSE, 32'h0000_1001, 16'd3, 32'd4, vinsn_pkg::EW16, 0, 0, 1'b1);
    add_entry(vinsn_pkg::VSE, 32'h0000_4FFC, 16'd10, 32'd0, vinsn_pkg::EW32, 12, 0, 1'b0);
    add_entry(vinsn_pkg::VSE, 32'h0000_6003, 16'd20, 32'd0, vinsn_pkg::EW8, 0, 0, 1'b0);
    add_entry(vinsn_pkg::VADD, 32'h0000_7000, 16'd8, 32'd0, vinsn_pkg::EW32, 0, 0, 1'b0);
    wd_cycles = (exp_q.size() + 20) * 40;

    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    for (int i = 0; i < stim.size(); i++) begin
      run_entry(i, exp_done);
    end

    // Let the LSU queue drain
    cycles = 0;
    while (pop_idx < exp_q.size() && cycles < 200) begin
      @(posedge clk_i);
      cycles++;
    end
    if (pop_idx != exp_q.size()) begin
      $display("ERROR at %0t: LSU queue not drained, %0d of %0d popped", $time, pop_idx,
               exp_q.size());
      err_count++;
    end

    $display("Summary: %0d entries, %0d requests, %0d pops, %0d errors", stim.size(),
             ax_idx, pop_idx, err_count);
    if (err_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/ax_issue_queue.sv */
/*
 * AR/AW issue stage
 * Drives the address channels and queues each request for the load/store units
 */
`default_nettype none

module ax_issue_queue (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire axi_addr_pkg::lsu_cmd_t  cmd_i,
  input  wire logic                    cmd_valid_i,
  output logic                         cmd_ready_o,
  output axi_addr_pkg::axi_ax_t        ar_o,
  output axi_addr_pkg::axi_ax_t        aw_o,
  output logic                         ar_valid_o,
  output logic                         aw_valid_o,
  input  wire logic                    ar_ready_i,
  input  wire logic                    aw_ready_i,
  output axi_addr_pkg::lsu_cmd_t       lsu_cmd_o,
  output logic                         lsu_cmd_valid_o,
  input  wire logic                    ldu_ready_i,
  input  wire logic                    stu_ready_i
);

  axi_addr_pkg::lsu_cmd_t                mem_q [axi_addr_pkg::LSU_Q_DEPTH];
  logic [axi_addr_pkg::LSU_Q_PTR_W-1:0]  wr_ptr_q;
  logic [axi_addr_pkg::LSU_Q_PTR_W-1:0]  rd_ptr_q;
  logic [axi_addr_pkg::LSU_Q_PTR_W:0]    count_q;
  axi_addr_pkg::axi_ax_t                 ax;
  logic                                  full;
  logic                                  empty;
  logic                                  chan_ready;
  logic                                  push;
  logic                                  pop;

  // Same payload on both channels, only the valid is steered
  assign ax = '{
    addr:  cmd_i.addr,
    len:   cmd_i.len,
    size:  cmd_i.size,
    burst: axi_addr_pkg::BURST_INCR,
    cache: axi_addr_pkg::CACHE_MODIFIABLE
  };
  assign ar_o = ax;
  assign aw_o = ax;

  assign full  = (count_q == axi_addr_pkg::LSU_Q_DEPTH);
  assign empty = (count_q == '0);

  assign chan_ready  = cmd_i.is_load ? ar_ready_i : aw_ready_i;
  assign cmd_ready_o = !full && chan_ready;
  assign ar_valid_o  = cmd_valid_i && cmd_i.is_load && !full;
  assign aw_valid_o  = cmd_valid_i && !cmd_i.is_load && !full;

  // Queue entry written in the handshake cycle
  assign push = cmd_valid_i && cmd_ready_o;
  assign pop  = !empty && (ldu_ready_i || stu_ready_i);

  assign lsu_cmd_o       = mem_q[rd_ptr_q];
  assign lsu_cmd_valid_o = !empty;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == axi_addr_pkg::LSU_Q_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == axi_addr_pkg::LSU_Q_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= cmd_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/axi_addr_pkg.sv */
/*
 * AXI address channel definitions
 * Bus widths, page and burst limits, address and load/store command records
 */
`default_nettype none

package axi_addr_pkg;

  localparam int unsigned ADDR_W         = 32;
  localparam int unsigned DATA_BYTES     = 8;
  localparam int unsigned DATA_BYTES_LOG = 3;

  // A burst stays inside one 4 KiB page
  localparam int unsigned PAGE_BITS       = 12;
  localparam int unsigned MAX_BURST_BEATS = 256;

  localparam logic [1:0] BURST_INCR       = 2'b01;
  localparam logic [3:0] CACHE_MODIFIABLE = 4'b0010;

  // Command queue toward the load/store units
  localparam int unsigned LSU_Q_DEPTH = 2;
  localparam int unsigned LSU_Q_PTR_W = $clog2(LSU_Q_DEPTH);

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [7:0]        axi_len_t;
  typedef logic [2:0]        axi_size_t;

  // AR/AW payload
  typedef struct packed {
    addr_t      addr;
    axi_len_t   len;
    axi_size_t  size;
    logic [1:0] burst;
    logic [3:0] cache;
  } axi_ax_t;

  // Copy of each issued request for the load/store units
  typedef struct packed {
    addr_t     addr;
    axi_len_t  len;
    axi_size_t size;
    logic      is_load;
  } lsu_cmd_t;

endpackage

`default_nettype wire

/* rtl/burst_planner.sv */
/*
 * Burst planner
 * Splits a job into page-safe INCR bursts or single-beat strided requests
 */
`default_nettype none

module burst_planner (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire vinsn_pkg::plan_job_t  job_i,
  input  wire logic                  job_valid_i,
  input  wire logic                  core_st_pending_i,
  output axi_addr_pkg::lsu_cmd_t     cmd_o,
  output logic                       cmd_valid_o,
  input  wire logic                  cmd_ready_i,
  output logic                       job_done_o
);

  typedef enum logic [1:0] {
    PLAN_IDLE,
    PLAN_WAIT,
    PLAN_ISSUE
  } plan_state_e;

  plan_state_e          state_q, state_d;
  vinsn_pkg::plan_job_t job_q;
  axi_addr_pkg::addr_t  start_q;
  axi_addr_pkg::addr_t  end_q;
  axi_addr_pkg::addr_t  span;
  axi_addr_pkg::addr_t  consumed;
  axi_addr_pkg::addr_t  next_addr;
  vinsn_pkg::vlen_t     next_len;
  logic                 accept;

  //////////////////////////////////////////////////
  // Burst bounds
  //////////////////////////////////////////////////

  function automatic axi_addr_pkg::addr_t align_down(input axi_addr_pkg::addr_t a);
    return {a[axi_addr_pkg::ADDR_W-1:axi_addr_pkg::DATA_BYTES_LOG],
            {axi_addr_pkg::DATA_BYTES_LOG{1'b0}}};
  endfunction

  // Last byte covered by a burst starting at addr
  function automatic axi_addr_pkg::addr_t burst_end(input axi_addr_pkg::addr_t addr,
                                                    input vinsn_pkg::vlen_t    len,
                                                    input vinsn_pkg::vew_e     vew);
    axi_addr_pkg::addr_t bytes;
    axi_addr_pkg::addr_t last;
    bytes = axi_addr_pkg::addr_t'(len) << vew;
    // At most 256 full-width beats
    if (bytes > axi_addr_pkg::MAX_BURST_BEATS * axi_addr_pkg::DATA_BYTES) begin
      bytes = axi_addr_pkg::MAX_BURST_BEATS * axi_addr_pkg::DATA_BYTES;
    end
    last = align_down(addr + bytes - 1) + (axi_addr_pkg::DATA_BYTES - 1);
    // Clamp to the end of the starting page
    if (last[axi_addr_pkg::ADDR_W-1:axi_addr_pkg::PAGE_BITS] !=
        addr[axi_addr_pkg::ADDR_W-1:axi_addr_pkg::PAGE_BITS]) begin
      last = {addr[axi_addr_pkg::ADDR_W-1:axi_addr_pkg::PAGE_BITS],
              {axi_addr_pkg::PAGE_BITS{1'b1}}};
    end
    return last;
  endfunction

  //////////////////////////////////////////////////
  // Current request and next position
  //////////////////////////////////////////////////

  always_comb begin
    cmd_o.addr    = job_q.addr;
    cmd_o.is_load = job_q.is_load;
    if (job_q.is_burst) begin
      cmd_o.len  = axi_addr_pkg::axi_len_t'((end_q - start_q) >> axi_addr_pkg::DATA_BYTES_LOG);
      cmd_o.size = axi_addr_pkg::axi_size_t'(axi_addr_pkg::DATA_BYTES_LOG);
    end else begin
      cmd_o.len  = '0;
      cmd_o.size = axi_addr_pkg::axi_size_t'(job_q.vew);
    end
  end

  always_comb begin
    // Elements covered by the current burst
    span     = end_q - job_q.addr + 1;
    consumed = span >> job_q.vew;
    if (job_q.is_burst) begin
      next_addr = end_q + 1;
      if (consumed >= job_q.len) begin
        next_len = '0;
      end else begin
        next_len = job_q.len - consumed[vinsn_pkg::VLEN_W-1:0];
      end
    end else begin
      next_addr = job_q.addr + job_q.stride;
      next_len  = job_q.len - 1'b1;
    end
  end

  assign accept = cmd_valid_o && cmd_ready_i;

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    cmd_valid_o = 1'b0;
    job_done_o  = 1'b0;

    case (state_q)
      PLAN_IDLE: begin
        if (job_valid_i) begin
          state_d = PLAN_WAIT;
        end
      end
      PLAN_WAIT: begin
        // Stores wait for the scalar core to drain its stores
        if (job_q.is_load || !core_st_pending_i) begin
          state_d = PLAN_ISSUE;
        end
      end
      PLAN_ISSUE: begin
        cmd_valid_o = 1'b1;
        if (cmd_ready_i && next_len == '0) begin
          job_done_o = 1'b1;
          state_d    = PLAN_IDLE;
        end
      end
      default: state_d = PLAN_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= PLAN_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == PLAN_IDLE && job_valid_i) begin
      job_q <= job_i;
    end else if (state_q == PLAN_WAIT) begin
      start_q <= align_down(job_q.addr);
      end_q   <= burst_end(job_q.addr, job_q.len, job_q.vew);
    end else if (accept) begin
      job_q.addr <= next_addr;
      job_q.len  <= next_len;
      start_q    <= align_down(next_addr);
      end_q      <= burst_end(next_addr, next_len, job_q.vew);
    end
  end

endmodule

`default_nettype wire

/* rtl/vaddr_gen.sv */
/*
 * Vector load/store address generator
 * Decoder, burst planner and AR/AW issue stage
 */
`default_nettype none

module vaddr_gen (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  // Sequencer side
  input  wire vinsn_pkg::vec_req_t     vinsn_i,
  input  wire logic                    vinsn_valid_i,
  input  wire logic                    core_st_pending_i,
  output logic                         ack_o,
  output logic                         error_o,
  // AXI address channels
  output axi_addr_pkg::axi_ax_t        ar_o,
  output logic                         ar_valid_o,
  input  wire logic                    ar_ready_i,
  output axi_addr_pkg::axi_ax_t        aw_o,
  output logic                         aw_valid_o,
  input  wire logic                    aw_ready_i,
  // Load/store units
  output axi_addr_pkg::lsu_cmd_t       lsu_cmd_o,
  output logic                         lsu_cmd_valid_o,
  input  wire logic                    ldu_ready_i,
  input  wire logic                    stu_ready_i
);

  vinsn_pkg::plan_job_t   job;
  logic                   job_valid;
  logic                   job_done;
  axi_addr_pkg::lsu_cmd_t cmd;
  logic                   cmd_valid;
  logic                   cmd_ready;

  vmem_decoder u_decoder (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .vinsn_i       (vinsn_i),
    .vinsn_valid_i (vinsn_valid_i),
    .job_done_i    (job_done),
    .job_o         (job),
    .job_valid_o   (job_valid),
    .ack_o         (ack_o),
    .error_o       (error_o)
  );

  burst_planner u_planner (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .job_i             (job),
    .job_valid_i       (job_valid),
    .core_st_pending_i (core_st_pending_i),
    .cmd_o             (cmd),
    .cmd_valid_o       (cmd_valid),
    .cmd_ready_i       (cmd_ready),
    .job_done_o        (job_done)
  );

  ax_issue_queue u_issue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .cmd_i           (cmd),
    .cmd_valid_i     (cmd_valid),
    .cmd_ready_o     (cmd_ready),
    .ar_o            (ar_o),
    .aw_o            (aw_o),
    .ar_valid_o      (ar_valid_o),
    .aw_valid_o      (aw_valid_o),
    .ar_ready_i      (ar_ready_i),
    .aw_ready_i      (aw_ready_i),
    .lsu_cmd_o       (lsu_cmd_o),
    .lsu_cmd_valid_o (lsu_cmd_valid_o),
    .ldu_ready_i     (ldu_ready_i),
    .stu_ready_i     (stu_ready_i)
  );

endmodule

`default_nettype wire

/* rtl/vinsn_pkg.sv */
/*
 * Vector instruction definitions
 * Opcodes, element widths and the instruction and job records
 */
`default_nettype none

package vinsn_pkg;

  // Length and stride field widths
  localparam int unsigned VLEN_W = 16;
  localparam int unsigned ELEN_W = 32;

  typedef logic [VLEN_W-1:0] vlen_t;
  typedef logic [ELEN_W-1:0] stride_t;

  // Opcodes seen by the address generator
  typedef enum logic [2:0] {
    VLE  = 3'd0,
    VSE  = 3'd1,
    VLSE = 3'd2,
    VSSE = 3'd3,
    VADD = 3'd4,
    VMUL = 3'd5
  } vop_e;

  // Value is log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Instruction as held by the sequencer, addresses share the bus width
  typedef struct packed {
    vop_e                            op;
    logic [axi_addr_pkg::ADDR_W-1:0] addr;
    vlen_t                           vl;
    stride_t                         stride;
    vew_e                            vew;
  } vec_req_t;

  // Checked job for the burst planner
  typedef struct packed {
    logic [axi_addr_pkg::ADDR_W-1:0] addr;
    vlen_t                           len;
    stride_t                         stride;
    vew_e                            vew;
    logic                            is_load;
    // Unit-stride jobs become INCR bursts
    logic                            is_burst;
  } plan_job_t;

endpackage

`default_nettype wire

/* rtl/vmem_decoder.sv */
/*
 * Vector memory instruction decoder
 * Accepts load/store instructions, rejects misaligned bases, hands jobs on
 */
`default_nettype none

module vmem_decoder (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire vinsn_pkg::vec_req_t  vinsn_i,
  input  wire logic                 vinsn_valid_i,
  input  wire logic                 job_done_i,
  output vinsn_pkg::plan_job_t      job_o,
  output logic                      job_valid_o,
  output logic                      ack_o,
  output logic                      error_o
);

  typedef enum logic {
    DEC_IDLE,
    DEC_BUSY
  } dec_state_e;

  dec_state_e state_q, state_d;
  logic       done_q;
  logic       is_mem;
  logic       misaligned;
  logic [2:0] ew_mask;

  // Other opcodes belong to other units
  assign is_mem = vinsn_i.op inside {vinsn_pkg::VLE, vinsn_pkg::VSE,
                                     vinsn_pkg::VLSE, vinsn_pkg::VSSE};

  // Low address bits that must be zero for the element width
  assign ew_mask    = 3'((4'd1 << vinsn_i.vew) - 4'd1);
  assign misaligned = |(vinsn_i.addr[2:0] & ew_mask);

  assign job_o = '{
    addr:     vinsn_i.addr,
    len:      vinsn_i.vl,
    stride:   vinsn_i.stride,
    vew:      vinsn_i.vew,
    is_load:  vinsn_i.op inside {vinsn_pkg::VLE, vinsn_pkg::VLSE},
    is_burst: vinsn_i.op inside {vinsn_pkg::VLE, vinsn_pkg::VSE}
  };

  always_comb begin
    state_d     = state_q;
    job_valid_o = 1'b0;
    ack_o       = 1'b0;
    error_o     = 1'b0;

    case (state_q)
      DEC_IDLE: begin
        if (vinsn_valid_i && is_mem) begin
          if (misaligned) begin
            ack_o   = 1'b1;
            error_o = 1'b1;
          end else if (vinsn_i.vl == '0) begin
            // Nothing to transfer
            ack_o = 1'b1;
          end else begin
            job_valid_o = 1'b1;
            state_d     = DEC_BUSY;
          end
        end
      end
      DEC_BUSY: begin
        // Ack one cycle after the last request went out
        if (done_q) begin
          ack_o   = 1'b1;
          state_d = DEC_IDLE;
        end
      end
      default: state_d = DEC_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DEC_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= job_done_i;
    end
  end

endmodule

`default_nettype wire

/* vaddr_gen.f */
rtl/axi_addr_pkg.sv
rtl/vinsn_pkg.sv
rtl/vmem_decoder.sv
rtl/burst_planner.sv
rtl/ax_issue_queue.sv
rtl/vaddr_gen.sv
bench/vaddr_gen_tb.sv
